//--- logic/mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

    localparam int xlen = 32;

    // operation kind from execute
    localparam logic [1:0] mem_op_none   = 2'd0;
    localparam logic [1:0] mem_op_load   = 2'd1;
    localparam logic [1:0] mem_op_store  = 2'd2;
    localparam logic [1:0] mem_op_atomic = 2'd3;

    localparam logic [1:0] size_byte = 2'd0;
    localparam logic [1:0] size_half = 2'd1;
    localparam logic [1:0] size_word = 2'd2;

    localparam logic [3:0] amo_lr   = 4'd0;
    localparam logic [3:0] amo_sc   = 4'd1;
    localparam logic [3:0] amo_swap = 4'd2;
    localparam logic [3:0] amo_add  = 4'd3;
    localparam logic [3:0] amo_xor  = 4'd4;
    localparam logic [3:0] amo_and  = 4'd5;
    localparam logic [3:0] amo_or   = 4'd6;
    localparam logic [3:0] amo_min  = 4'd7;
    localparam logic [3:0] amo_max  = 4'd8;

    localparam logic sign_signed   = 1'b0;
    localparam logic sign_unsigned = 1'b1;

    // mcause values
    localparam logic [3:0] cause_load_access_fault  = 4'd5;
    localparam logic [3:0] cause_store_access_fault = 4'd7;
    localparam logic [3:0] cause_load_page_fault    = 4'd13;
    localparam logic [3:0] cause_store_page_fault   = 4'd15;

    localparam int mem_words     = 256; // 1 KiB
    localparam int mem_addr_bits = $clog2(mem_words);
    localparam logic [xlen-1:0] page_fault_base = 32'h8000_0000;
    localparam int mem_latency   = 2;

    localparam logic [xlen-1:0] no_reservation = '1;

    // sequencer states
    localparam logic [1:0] st_idle        = 2'd0;
    localparam logic [1:0] st_wait_accept = 2'd1;
    localparam logic [1:0] st_wait_read   = 2'd2;
    localparam logic [1:0] st_wait_write  = 2'd3;

    // one memory word, seen as bytes or as halves
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_lanes_t;

endpackage

`default_nettype wire

//--- logic/load_aligner.sv
`default_nettype none

module load_aligner
    import mem_stage_pkg::*;
(
    input  wire [xlen-1:0]  word,
    input  wire [1:0]       byte_sel,
    input  wire [1:0]       mem_size,
    input  wire             sign,
    output logic [xlen-1:0] value
);

    mem_lanes_t lanes;
    logic [7:0]  byte_val;
    logic [15:0] half_val;
    logic        ext_b;
    logic        ext_h;

    assign lanes    = word;
    assign byte_val = lanes.bytes[byte_sel];
    assign half_val = lanes.halves[byte_sel[1]]; // upper bit picks the half

    // unsigned loads fill with zero
    assign ext_b = (sign == sign_unsigned) ? 1'b0 : byte_val[7];
    assign ext_h = (sign == sign_unsigned) ? 1'b0 : half_val[15];

    always_comb begin
        case (mem_size)
            size_byte: value = {{24{ext_b}}, byte_val};
            size_half: value = {{16{ext_h}}, half_val};
            default:   value = word;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/amo_alu.sv
`default_nettype none

module amo_alu
    import mem_stage_pkg::*;
(
    input  wire [xlen-1:0]  old_word,
    input  wire [xlen-1:0]  rs2_data,
    input  wire [3:0]       amo_op,
    input  wire             sign,
    output logic [xlen-1:0] new_word
);

    logic old_less;

    // ordering for min/max
    always_comb begin
        if (sign == sign_signed) begin
            old_less = $signed(old_word) < $signed(rs2_data);
        end else begin
            old_less = old_word < rs2_data;
        end
    end

    always_comb begin
        case (amo_op)
            amo_swap: new_word = rs2_data;
            amo_add:  new_word = old_word + rs2_data;
            amo_xor:  new_word = old_word ^ rs2_data;
            amo_and:  new_word = old_word & rs2_data;
            amo_or:   new_word = old_word | rs2_data;
            amo_min:  new_word = old_less ? old_word : rs2_data;
            amo_max:  new_word = old_less ? rs2_data : old_word;
            default:  new_word = '0; // lr, sc never write through here
        endcase
    end

endmodule

`default_nettype wire

//--- logic/access_sequencer.sv
`default_nettype none

module access_sequencer
    import mem_stage_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             valid,
    input  wire [1:0]       mem_op,
    input  wire [1:0]       mem_size,
    input  wire             sign,
    input  wire [3:0]       amo_op,
    input  wire [xlen-1:0]  addr,
    input  wire [xlen-1:0]  rs2_data,
    input  wire             accept,
    input  wire             resp_valid,
    input  wire [xlen-1:0]  resp_rdata,
    input  wire             resp_error,
    input  wire             resp_page_fault,
    input  wire [xlen-1:0]  aligned_value,
    input  wire [xlen-1:0]  amo_value,
    output logic            req,
    output logic            req_wen,
    output logic [xlen-1:0] req_addr,
    output logic [xlen-1:0] req_wdata,
    output logic [1:0]      req_size,
    output logic [xlen-1:0] saved_word,
    output logic            stall,
    output logic [xlen-1:0] rdata,
    output logic            trap_valid,
    output logic [3:0]      trap_cause
);

    logic [1:0]      state;
    logic            done;
    logic            amo_write; // second half of an amo
    logic            sc_ok;
    logic            fault;
    logic            fault_page;
    logic [xlen-1:0] reservation;

    logic is_atomic;
    logic is_lr;
    logic is_sc;
    logic is_rmw;
    logic load_kind;
    logic sc_match;

    assign is_atomic = mem_op == mem_op_atomic;
    assign is_lr     = is_atomic && amo_op == amo_lr;
    assign is_sc     = is_atomic && amo_op == amo_sc;
    assign is_rmw    = is_atomic && !is_lr && !is_sc;
    assign load_kind = mem_op == mem_op_load || is_lr;
    assign sc_match  = addr == reservation;

    assign stall = valid && mem_op != mem_op_none && !done;

    assign req       = state == st_wait_accept;
    assign req_wen   = mem_op == mem_op_store || is_sc || amo_write;
    assign req_addr  = addr;
    assign req_wdata = amo_write ? amo_value : rs2_data;
    assign req_size  = mem_size;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= st_idle;
            done        <= 1'b0;
            amo_write   <= 1'b0;
            sc_ok       <= 1'b0;
            fault       <= 1'b0;
            fault_page  <= 1'b0;
            reservation <= no_reservation;
        end else begin
            case (state)
                st_idle: begin
                    if (done) begin
                        if (valid) done <= 1'b0; // completion cycle
                    end else if (stall) begin
                        fault <= 1'b0;
                        if (is_sc) begin
                            reservation <= no_reservation;
                            sc_ok       <= sc_match;
                            if (sc_match) state <= st_wait_accept;
                            else          done  <= 1'b1; // no access at all
                        end else begin
                            if (is_lr) reservation <= addr;
                            state <= st_wait_accept;
                        end
                    end
                end
                st_wait_accept: begin
                    if (accept) state <= req_wen ? st_wait_write : st_wait_read;
                end
                st_wait_read: begin
                    if (resp_valid) begin
                        fault      <= resp_error;
                        fault_page <= resp_page_fault;
                        if (is_rmw && !resp_error) begin
                            amo_write <= 1'b1; // now store the alu result
                            state     <= st_wait_accept;
                        end else begin
                            done  <= 1'b1;
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    if (resp_valid) begin
                        fault      <= resp_error;
                        fault_page <= resp_page_fault;
                        amo_write  <= 1'b0;
                        done       <= 1'b1;
                        state      <= st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_wait_read && resp_valid) saved_word <= resp_rdata;
    end

    always_comb begin
        if (is_sc) begin
            rdata = sc_ok ? '0 : xlen'(1);
        end else if (is_atomic) begin
            rdata = saved_word; // lr and amo return the old word
        end else begin
            rdata = aligned_value;
        end
    end

    assign trap_valid = done && fault;

    always_comb begin
        if (!fault)          trap_cause = 4'd0;
        else if (fault_page) trap_cause = load_kind ? cause_load_page_fault
                                                    : cause_store_page_fault;
        else                 trap_cause = load_kind ? cause_load_access_fault
                                                    : cause_store_access_fault;
    end

endmodule

`default_nettype wire

//--- logic/data_mem.sv
`default_nettype none

module data_mem
    import mem_stage_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             req,
    input  wire             req_wen,
    input  wire [xlen-1:0]  req_addr,
    input  wire [xlen-1:0]  req_wdata,
    input  wire [1:0]       req_size,
    output logic            accept,
    output logic            resp_valid,
    output logic [xlen-1:0] resp_rdata,
    output logic            resp_error,
    output logic            resp_page_fault
);

    logic [xlen-1:0] mem [mem_words];

    logic                     busy;
    logic [1:0]               lat_cnt;
    logic                     wen_q;
    logic [xlen-1:0]          addr_q;
    logic [xlen-1:0]          wdata_q;
    logic [1:0]               size_q;
    logic [mem_addr_bits-1:0] idx;
    logic                     page_fault;
    logic                     access_fault;
    mem_lanes_t               merged;

    assign idx          = addr_q[2 +: mem_addr_bits];
    assign page_fault   = addr_q >= page_fault_base;
    assign access_fault = !page_fault && addr_q[xlen-1:2] >= mem_words;

    // byte-masked write word
    always_comb begin
        merged = mem[idx];
        case (size_q)
            size_byte: merged.bytes[addr_q[1:0]] = wdata_q[7:0];
            size_half: merged.halves[addr_q[1]]  = wdata_q[15:0];
            default:   merged = wdata_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy            <= 1'b0;
            lat_cnt         <= '0;
            accept          <= 1'b0;
            resp_valid      <= 1'b0;
            resp_error      <= 1'b0;
            resp_page_fault <= 1'b0;
            for (int i = 0; i < mem_words; i++) mem[i] <= '0;
        end else begin
            accept     <= 1'b0;
            resp_valid <= 1'b0;
            if (!busy) begin
                if (req) begin
                    accept  <= 1'b1;
                    busy    <= 1'b1;
                    lat_cnt <= 2'(mem_latency - 1);
                end
            end else if (lat_cnt != 2'd0) begin
                lat_cnt <= lat_cnt - 2'd1;
            end else begin
                busy            <= 1'b0;
                resp_valid      <= 1'b1;
                resp_error      <= page_fault || access_fault;
                resp_page_fault <= page_fault;
                if (wen_q && !page_fault && !access_fault) mem[idx] <= merged;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && req) begin
            wen_q   <= req_wen;
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            size_q  <= req_size;
        end
        if (busy && lat_cnt == 2'd0) resp_rdata <= mem[idx]; // whole aligned word
    end

endmodule

`default_nettype wire

//--- logic/mem_subsystem.sv
`default_nettype none

module mem_subsystem
    import mem_stage_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire             valid,
    input  wire [1:0]       mem_op,
    input  wire [1:0]       mem_size,
    input  wire             sign,
    input  wire [3:0]       amo_op,
    input  wire [xlen-1:0]  addr,
    input  wire [xlen-1:0]  rs2_data,
    output logic            stall,
    output logic [xlen-1:0] rdata,
    output logic            trap_valid,
    output logic [3:0]      trap_cause
);

    logic            req;
    logic            req_wen;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;
    logic [1:0]      req_size;
    logic            accept;
    logic            resp_valid;
    logic [xlen-1:0] resp_rdata;
    logic            resp_error;
    logic            resp_page_fault;
    logic [xlen-1:0] saved_word;
    logic [xlen-1:0] aligned_value;
    logic [xlen-1:0] amo_value;

    access_sequencer seq0 (
        .clk, .reset, .valid, .mem_op, .mem_size, .sign, .amo_op, .addr, .rs2_data,
        .accept, .resp_valid, .resp_rdata, .resp_error, .resp_page_fault,
        .aligned_value, .amo_value,
        .req, .req_wen, .req_addr, .req_wdata, .req_size, .saved_word,
        .stall, .rdata, .trap_valid, .trap_cause
    );

    load_aligner align0 (
        .word     (saved_word),
        .byte_sel (addr[1:0]),
        .mem_size (mem_size),
        .sign     (sign),
        .value    (aligned_value)
    );

    amo_alu alu0 (
        .old_word (saved_word),
        .rs2_data (rs2_data),
        .amo_op   (amo_op),
        .sign     (sign),
        .new_word (amo_value)
    );

    data_mem mem0 (
        .clk, .reset, .req, .req_wen, .req_addr, .req_wdata, .req_size,
        .accept, .resp_valid, .resp_rdata, .resp_error, .resp_page_fault
    );

endmodule

`default_nettype wire

//--- dv/clk_gen.sv
`default_nettype none

module clk_gen (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- dv/mem_checker.sv
`default_nettype none

module mem_checker
    import mem_stage_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire        valid,
    input  wire        stall,
    input  wire [1:0]  mem_op,
    input  wire [31:0] rdata,
    input  wire        trap_valid,
    input  wire [3:0]  trap_cause,
    input  wire [31:0] exp_rdata,
    input  wire        exp_trap_valid,
    input  wire [3:0]  exp_trap_cause,
    input  int         vec_idx,
    output int         completions,
    output int         errors
);
    timeunit 1ns;
    timeprecision 100ps;

    always @(posedge clk) begin
        if (!reset && valid) begin
            // no memory work, so never a stall
            if (mem_op == mem_op_none && stall) begin
                $display("[FAIL] %0t vector %0d: stall expected 0, got 1", $time, vec_idx);
                errors = errors + 1;
            end
            if (!stall) begin
                completions = completions + 1;
                if (trap_valid !== exp_trap_valid) begin
                    $display("[FAIL] %0t vector %0d: trap_valid expected %0b, got %0b",
                             $time, vec_idx, exp_trap_valid, trap_valid);
                    errors = errors + 1;
                end else if (exp_trap_valid && trap_cause !== exp_trap_cause) begin
                    $display("[FAIL] %0t vector %0d: trap_cause expected %0d, got %0d",
                             $time, vec_idx, exp_trap_cause, trap_cause);
                    errors = errors + 1;
                end
                // rdata means nothing on a trap or a store
                if ((mem_op == mem_op_load || mem_op == mem_op_atomic) && !exp_trap_valid
                        && rdata !== exp_rdata) begin
                    $display("[FAIL] %0t vector %0d: rdata expected %h, got %h",
                             $time, vec_idx, exp_rdata, rdata);
                    errors = errors + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_subsystem.sv
`default_nettype none

module tb_mem_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_vecs = 64;
    localparam int vec_cols = 9; // words per vector line

    logic        clk;
    logic        reset;
    logic        valid;
    logic [1:0]  mem_op;
    logic [1:0]  mem_size;
    logic        sign;
    logic [3:0]  amo_op;
    logic [31:0] addr;
    logic [31:0] rs2_data;
    logic        stall;
    logic [31:0] rdata;
    logic        trap_valid;
    logic [3:0]  trap_cause;

    logic [31:0] exp_rdata;
    logic        exp_trap_valid;
    logic [3:0]  exp_trap_cause;
    int          vec_idx;
    int          n_vec;
    int          completions;
    int          errors;

    logic [31:0] vec_words [max_vecs*vec_cols];

    clk_gen clk0 (.clk, .reset);

    mem_subsystem dut0 (
        .clk, .reset, .valid, .mem_op, .mem_size, .sign, .amo_op, .addr, .rs2_data,
        .stall, .rdata, .trap_valid, .trap_cause
    );

    mem_checker chk0 (
        .clk, .reset, .valid, .stall, .mem_op, .rdata, .trap_valid, .trap_cause,
        .exp_rdata, .exp_trap_valid, .exp_trap_cause, .vec_idx,
        .completions, .errors
    );

    task automatic apply_vector(input int v);
        int base;
        base = v * vec_cols;
        vec_idx        <= v;
        valid          <= 1'b1;
        mem_op         <= vec_words[base][1:0];
        mem_size       <= vec_words[base+1][1:0];
        sign           <= vec_words[base+2][0];
        amo_op         <= vec_words[base+3][3:0];
        addr           <= vec_words[base+4];
        rs2_data       <= vec_words[base+5];
        exp_rdata      <= vec_words[base+6];
        exp_trap_valid <= vec_words[base+7][0];
        exp_trap_cause <= vec_words[base+8][3:0];
    endtask

    task automatic end_run(input int extra_errors);
        int total;
        total = errors + extra_errors;
        $display("%0d of %0d vectors completed, %0d errors", completions, n_vec, total);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    endtask

    initial begin
        int load_errors;
        int count;
        load_errors    = 0;
        count          = 0;
        valid          = 1'b0;
        mem_op         = '0;
        mem_size       = '0;
        sign           = 1'b0;
        amo_op         = '0;
        addr           = '0;
        rs2_data       = '0;
        exp_rdata      = '0;
        exp_trap_valid = 1'b0;
        exp_trap_cause = '0;
        vec_idx        = 0;
        // marker so the end of the file can be found
        for (int i = 0; i < max_vecs * vec_cols; i++) vec_words[i] = 32'hdead_beef;
        $readmemh("dv/mem_vectors.txt", vec_words);
        while (count < max_vecs && vec_words[count*vec_cols] != 32'hdead_beef) count++;
        n_vec = count;

        if (n_vec == 0) begin
            $display("ERROR: no vectors could be read from dv/mem_vectors.txt");
            load_errors = 1;
        end else begin
            @(posedge clk);
            while (reset) @(posedge clk);
            for (int v = 0; v < n_vec; v++) begin
                apply_vector(v);
                do begin
                    @(posedge clk);
                end while (stall); // hold until the completion cycle
            end
            valid <= 1'b0;
            @(posedge clk);
        end
        end_run(load_errors);
    end

    // hang guard
    initial begin
        int cycles;
        cycles = 0;
        wait (n_vec > 0);
        while (cycles < n_vec * 16 + 50) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, the memory stage hung on vector %0d",
                 cycles, vec_idx);
        end_run(1);
    end

endmodule

`default_nettype wire

//--- dv/mem_vectors.txt
// mem_op mem_size sign amo_op addr rs2_data exp_rdata exp_trap_valid exp_trap_cause
// mem_op 0 none 1 load 2 store 3 atomic; size 0 byte 1 half 2 word; sign 1 unsigned
2 2 0 0 00000010 f2817e93 00000000 0 0
1 0 0 0 00000010 00000000 ffffff93 0 0
1 0 1 0 00000010 00000000 00000093 0 0
1 0 0 0 00000011 00000000 0000007e 0 0
1 0 1 0 00000012 00000000 00000081 0 0
1 0 0 0 00000013 00000000 fffffff2 0 0
1 1 0 0 00000010 00000000 00007e93 0 0
1 1 1 0 00000012 00000000 0000f281 0 0
1 1 0 0 00000012 00000000 fffff281 0 0
2 0 0 0 00000011 000000a5 00000000 0 0
2 1 0 0 00000012 00001234 00000000 0 0
1 0 0 0 00000011 00000000 ffffffa5 0 0
1 2 0 0 00000010 00000000 1234a593 0 0
0 0 0 0 00000000 00000000 00000000 0 0
// lr and sc at 0x20
3 2 0 0 00000020 00000000 00000000 0 0
3 2 0 1 00000020 cafe0001 00000000 0 0
1 2 0 0 00000020 00000000 cafe0001 0 0
3 2 0 1 00000020 11111111 00000001 0 0
3 2 0 0 00000020 00000000 cafe0001 0 0
3 2 0 1 00000024 22222222 00000001 0 0
1 2 0 0 00000020 00000000 cafe0001 0 0
1 2 0 0 00000024 00000000 00000000 0 0
// amo chain at 0x30, each returns the previous result
3 2 0 2 00000030 80000005 00000000 0 0
3 2 0 3 00000030 00000010 80000005 0 0
3 2 0 4 00000030 0000ffff 80000015 0 0
3 2 0 5 00000030 f0f0f0f0 8000ffea 0 0
3 2 0 6 00000030 00000003 8000f0e0 0 0
3 2 0 7 00000030 00000001 8000f0e3 0 0
3 2 1 7 00000030 00000001 8000f0e3 0 0
3 2 0 8 00000030 fffffffe 00000001 0 0
3 2 1 8 00000030 fffffffe 00000001 0 0
1 2 0 0 00000030 00000000 fffffffe 0 0
// access and page faults
1 2 0 0 00000400 00000000 00000000 1 5
2 2 0 0 00000400 5555aaaa 00000000 1 7
1 2 0 0 00000000 00000000 00000000 0 0
1 2 0 0 80000010 00000000 00000000 1 d
2 2 0 0 80000010 deadbeef 00000000 1 f
1 2 0 0 00000010 00000000 1234a593 0 0
3 2 0 3 80000030 00000001 00000000 1 f

//--- flist.f
logic/mem_stage_pkg.sv
logic/load_aligner.sv
logic/amo_alu.sv
logic/access_sequencer.sv
logic/data_mem.sv
logic/mem_subsystem.sv
dv/clk_gen.sv
dv/mem_checker.sv
dv/tb_mem_subsystem.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timescale 1ns/1ps -Wno-fatal --top-module tb_mem_subsystem -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_mem_subsystem | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
